//--- vlog.f
src/stride_pkg.sv
src/stream_if.sv
src/cmd_skid_buffer.sv
src/addr_gen_nd.sv
src/buffer_read_port.sv
src/stride_read_top.sv
verif/stride_read_chk.sv
verif/tb_stride_read.sv

//--- run.sh
#!/bin/sh
# build and run the strided read testbench with Verilator
verilator --binary --timing --assert -f vlog.f --top-module tb_stride_read || exit 1
out=$(./obj_dir/Vtb_stride_read +verilator+error+limit+100000)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

//--- verif/tb_stride_read.sv
/*
 * testbench for the strided read engine with buffer load, command stimulus,
 * queue reference model and per-test report
 */

`timescale 1ns/1ps
`default_nettype none

module tb_stride_read;

    localparam int dims    = stride_pkg::dims_default;
    localparam int addr_w  = stride_pkg::addr_w_default;
    localparam int step_w  = stride_pkg::step_w_default;
    localparam int len_w   = stride_pkg::len_w_default;
    localparam int data_w  = stride_pkg::data_w_default;
    localparam int tag_w   = stride_pkg::tag_w_default;
    localparam int beat_w  = data_w + 2 * dims + tag_w;
    localparam int timeout = 50000;

    logic                        clk;
    logic                        reset;
    logic [addr_w-1:0]           cmd_base;
    logic [dims-1:0][step_w-1:0] cmd_step;
    logic [dims-1:0][len_w-1:0]  cmd_len;
    logic [tag_w-1:0]            cmd_tag;
    logic                        cmd_valid;
    logic                        cmd_ready;
    logic [data_w-1:0]           rd_data;
    logic [dims-1:0]             rd_first;
    logic [dims-1:0]             rd_last;
    logic [tag_w-1:0]            rd_tag;
    logic                        rd_valid;
    logic                        rd_ready;
    logic                        wr_en;
    logic [addr_w-1:0]           wr_addr;
    logic [data_w-1:0]           wr_data;

    logic [31:0]       lfsr = 32'h6915;
    logic [beat_w-1:0] expected [$];
    logic [beat_w-1:0] exp_beat;
    logic              stall = 1'b0;
    logic              timed_out = 1'b0;
    int                errors = 0;
    int                tests = 0;
    int                mark = 0;

    stride_read_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci LFSR with taps 32 22 2 1, stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // buffer fill word that uses every address bit
    function automatic logic [data_w-1:0] scramble(input logic [addr_w-1:0] a);
        return {a[3:0], a[9:4], ~a[5:0]} ^ 16'h5a3c;
    endfunction

    // dimension 0 up to 16 long and outer ones up to 4
    function automatic logic [dims-1:0][len_w-1:0] random_len();
        logic [dims-1:0][len_w-1:0] len;
        for (int d = 0; d < dims; d++) begin
            len[d] = len_w'(take_bits(d == 0 ? len_w : 2));
        end
        return len;
    endfunction

    function automatic int total_errors();
        return errors + int'(dut_i.chk_i.hold_fails + dut_i.chk_i.reset_fails
            + dut_i.chk_i.order_fails);
    endfunction

    // --------------------
    // reference model
    // --------------------

    // expected beats of one command with dimension 0 fastest
    task automatic expand(input logic [addr_w-1:0] base,
                          input logic [dims-1:0][step_w-1:0] step,
                          input logic [dims-1:0][len_w-1:0] len,
                          input logic [tag_w-1:0] tag);
        int                idx [dims];
        logic [addr_w-1:0] addr;
        logic [dims-1:0]   first;
        logic [dims-1:0]   last;
        logic              all_first;
        logic              all_last;
        logic              carry;
        foreach (idx[d]) idx[d] = 0;
        carry = 1'b0;
        while (!carry) begin
            addr = base;
            all_first = 1'b1;
            all_last = 1'b1;
            for (int d = 0; d < dims; d++) begin
                addr = addr + addr_w'(idx[d] * int'(step[d]));
                all_first = all_first && (idx[d] == 0);
                all_last = all_last && (idx[d] == int'(len[d]));
                first[d] = all_first;
                last[d] = all_last;
            end
            expected.push_back({scramble(addr), first, last, tag});
            carry = 1'b1;
            for (int d = 0; d < dims; d++) begin
                if (carry) begin
                    if (idx[d] == int'(len[d])) begin
                        idx[d] = 0;
                    end else begin
                        idx[d] = idx[d] + 1;
                        carry = 1'b0;
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset && cmd_valid && cmd_ready) begin
            expand(cmd_base, cmd_step, cmd_len, cmd_tag);
        end
    end

    always @(posedge clk) begin
        if (!reset && rd_valid && rd_ready) begin
            assert (expected.size() != 0) else begin
                $display("read beat at %0t arrived with no beat expected", $time);
                errors++;
            end
            if (expected.size() != 0) begin
                exp_beat = expected.pop_front();
                assert ({rd_data, rd_first, rd_last, rd_tag} == exp_beat) else begin
                    $display("mismatch at %0t: read beat %h, expected %h", $time,
                        {rd_data, rd_first, rd_last, rd_tag}, exp_beat);
                    errors++;
                end
            end
        end
    end

    // consumer ready about three cycles in four
    always @(posedge clk) begin
        rd_ready <= !stall && (take_bits(2) != 0);
    end

    // --------------------
    // stimulus tasks
    // --------------------
    task automatic drive_cmd(input logic [dims-1:0][len_w-1:0] len);
        @(posedge clk);
        cmd_base  <= addr_w'(take_bits(addr_w));
        cmd_step  <= (dims * step_w)'(take_bits(dims * step_w));
        cmd_len   <= len;
        cmd_tag   <= tag_w'(take_bits(tag_w));
        cmd_valid <= 1'b1;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cmd_ready && n < timeout && !timed_out);
        if (!cmd_ready) begin
            $display("timeout at %0t, command was never accepted", $time);
            timed_out = 1'b1;
        end
        cmd_valid <= 1'b0;
    endtask

    // wait until every expected beat came out and report the test
    task automatic finish_test(input string name);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n >= timeout) begin
                $display("timeout at %0t, %s left beats undelivered", $time, name);
                timed_out = 1'b1;
            end
        end while ((expected.size() != 0 || rd_valid) && !timed_out);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, total_errors() - mark);
        mark = total_errors();
    endtask

    initial begin
        logic [dims-1:0][len_w-1:0] len;
        reset     = 1'b1;
        cmd_base  = '0;
        cmd_step  = '0;
        cmd_len   = '0;
        cmd_tag   = '0;
        cmd_valid = 1'b0;
        rd_ready  = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;

        repeat (15) begin
            @(negedge clk);
            assert (!rd_valid && !$isunknown(cmd_ready)) else begin
                $display("mismatch at %0t: read valid or cmd_ready wrong in reset", $time);
                errors++;
            end
        end
        @(posedge clk);
        reset <= 1'b0;
        finish_test("reset state");

        for (int a = 0; a < 2 ** addr_w; a++) begin
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= addr_w'(a);
            wr_data <= scramble(addr_w'(a));
        end
        @(posedge clk);
        wr_en <= 1'b0;

        drive_cmd('0);
        wait_accept();
        finish_test("degenerate lengths");

        // consumer stalled so the first command sits in the generator
        @(posedge clk);
        stall <= 1'b1;
        repeat (2) @(posedge clk);
        len = random_len();
        len[0] = len[0] | len_w'(1);
        drive_cmd(len);
        wait_accept();
        drive_cmd(len);
        wait_accept();
        drive_cmd(len);
        repeat (8) begin
            @(posedge clk);
            assert (!cmd_ready) else begin
                $display("mismatch at %0t: cmd_ready high with buffer full", $time);
                errors++;
            end
        end
        stall <= 1'b0;
        wait_accept();
        finish_test("command queueing");

        repeat (30) begin
            drive_cmd(random_len());
            wait_accept();
        end
        finish_test("random strided walks");

        $display("%0d tests, %0d errors", tests, total_errors());
        if (total_errors() == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/stride_read_chk.sv
/*
 * bound checks on the engine ports: back-pressure hold, reset state,
 * no read data before a command
 */

`timescale 1ns/1ps
`default_nettype none

module stride_read_chk #(
    parameter int dims   = stride_pkg::dims_default,
    parameter int data_w = stride_pkg::data_w_default,
    parameter int tag_w  = stride_pkg::tag_w_default
) (
    input logic              clk,
    input logic              reset,
    input logic              cmd_valid,
    input logic              cmd_ready,
    input logic [data_w-1:0] rd_data,
    input logic [dims-1:0]   rd_first,
    input logic [dims-1:0]   rd_last,
    input logic [tag_w-1:0]  rd_tag,
    input logic              rd_valid,
    input logic              rd_ready
);

    int unsigned hold_fails = 0;
    int unsigned reset_fails = 0;
    int unsigned order_fails = 0;
    logic        seen_cmd;

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_cmd <= 1'b0;
        end else if (cmd_valid && cmd_ready) begin
            seen_cmd <= 1'b1;
        end
    end

    // stalled output keeps its beat
    hold_a: assert property (@(posedge clk) disable iff (reset)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data) && $stable(rd_first)
            && $stable(rd_last) && $stable(rd_tag))
        else begin
            $error("read stream changed under back-pressure");
            hold_fails++;
        end

    reset_a: assert property (@(posedge clk)
        reset && $past(reset) |-> !rd_valid && !$isunknown(cmd_ready))
        else begin
            $error("read valid high or cmd_ready unknown in reset");
            reset_fails++;
        end

    order_a: assert property (@(posedge clk) disable iff (reset) rd_valid |-> seen_cmd)
        else begin
            $error("read valid before any accepted command");
            order_fails++;
        end

endmodule

bind stride_read_top stride_read_chk #(
    .dims(dims), .data_w(data_w), .tag_w(tag_w)
) chk_i (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .rd_data(rd_data), .rd_first(rd_first), .rd_last(rd_last), .rd_tag(rd_tag),
    .rd_valid(rd_valid), .rd_ready(rd_ready)
);

`default_nettype wire

//--- src/stride_read_top.sv
/*
 * strided read engine top: command buffer, address generator, read port
 */

`timescale 1ns/1ps
`default_nettype none

module stride_read_top #(
    parameter int dims   = stride_pkg::dims_default,
    parameter int addr_w = stride_pkg::addr_w_default,
    parameter int step_w = stride_pkg::step_w_default,
    parameter int len_w  = stride_pkg::len_w_default,
    parameter int data_w = stride_pkg::data_w_default,
    parameter int tag_w  = stride_pkg::tag_w_default
) (
    input  logic                        clk,
    input  logic                        reset,

    // command stream
    input  logic [addr_w-1:0]           cmd_base,
    input  logic [dims-1:0][step_w-1:0] cmd_step,
    input  logic [dims-1:0][len_w-1:0]  cmd_len,
    input  logic [tag_w-1:0]            cmd_tag,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,

    // read data stream
    output logic [data_w-1:0]           rd_data,
    output logic [dims-1:0]             rd_first,
    output logic [dims-1:0]             rd_last,
    output logic [tag_w-1:0]            rd_tag,
    output logic                        rd_valid,
    input  logic                        rd_ready,

    // buffer load
    input  logic                        wr_en,
    input  logic [addr_w-1:0]           wr_addr,
    input  logic [data_w-1:0]           wr_data
);

    cmd_if #(
        .dims(dims), .addr_w(addr_w), .step_w(step_w), .len_w(len_w), .tag_w(tag_w)
    ) cmd_q ();

    beat_if #(.dims(dims), .addr_w(addr_w), .tag_w(tag_w)) beat_q ();

    cmd_skid_buffer #(
        .dims(dims), .addr_w(addr_w), .step_w(step_w), .len_w(len_w), .tag_w(tag_w)
    ) cmd_buf_i (
        .clk(clk), .reset(reset),
        .cmd_base(cmd_base), .cmd_step(cmd_step), .cmd_len(cmd_len),
        .cmd_tag(cmd_tag), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .queued(cmd_q)
    );

    addr_gen_nd #(
        .dims(dims), .addr_w(addr_w), .len_w(len_w), .tag_w(tag_w)
    ) addr_gen_i (
        .clk(clk), .reset(reset), .cmd(cmd_q), .beat(beat_q)
    );

    buffer_read_port #(
        .dims(dims), .addr_w(addr_w), .data_w(data_w), .tag_w(tag_w)
    ) read_port_i (
        .clk(clk), .reset(reset),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .beat(beat_q),
        .rd_data(rd_data), .rd_first(rd_first), .rd_last(rd_last),
        .rd_tag(rd_tag), .rd_valid(rd_valid), .rd_ready(rd_ready)
    );

endmodule

`default_nettype wire

//--- src/buffer_read_port.sv
/*
 * local buffer RAM with plain write port and a stallable
 * registered read stage carrying flags and tag
 */

`timescale 1ns/1ps
`default_nettype none

module buffer_read_port #(
    parameter int dims   = stride_pkg::dims_default,
    parameter int addr_w = stride_pkg::addr_w_default,
    parameter int data_w = stride_pkg::data_w_default,
    parameter int tag_w  = stride_pkg::tag_w_default
) (
    input  logic              clk,
    input  logic              reset,

    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [data_w-1:0] wr_data,

    beat_if.sink              beat,

    output logic [data_w-1:0] rd_data,
    output logic [dims-1:0]   rd_first,
    output logic [dims-1:0]   rd_last,
    output logic [tag_w-1:0]  rd_tag,
    output logic              rd_valid,
    input  logic              rd_ready
);

    localparam int depth = 2 ** addr_w;

    logic [data_w-1:0] mem [depth];
    logic              accept;

    // output stage is empty or drains this cycle
    assign beat.ready = !rd_valid || rd_ready;
    assign accept     = beat.valid && beat.ready;

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------
    // read side
    // --------------------

    // read only on accept so data holds under back-pressure,
    // a same-cycle write gives the old word
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_data  <= mem[beat.addr];
            rd_first <= beat.first;
            rd_last  <= beat.last;
            rd_tag   <= beat.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else if (beat.ready) begin
            rd_valid <= beat.valid;
        end
    end

endmodule

`default_nettype wire

//--- src/addr_gen_nd.sv
/*
 * nested-loop address generator, dimension 0 innermost,
 * first/last flags per dimension on every beat
 */

`timescale 1ns/1ps
`default_nettype none

module addr_gen_nd #(
    parameter int dims   = stride_pkg::dims_default,
    parameter int addr_w = stride_pkg::addr_w_default,
    parameter int len_w  = stride_pkg::len_w_default,
    parameter int tag_w  = stride_pkg::tag_w_default
) (
    input  logic   clk,
    input  logic   reset,
    cmd_if.sink    cmd,
    beat_if.source beat
);

    stride_pkg::gen_state_e state;
    stride_pkg::gen_state_e next_state;

    // running start address and remaining count per dimension
    logic [dims-1:0][addr_w-1:0] run_addr;
    logic [dims-1:0][addr_w-1:0] next_addr;
    logic [dims-1:0][len_w-1:0]  run_len;
    logic [dims-1:0][len_w-1:0]  next_len;
    logic [dims-1:0]             run_first;
    logic [dims-1:0]             next_first;
    logic [dims-1:0]             run_last;
    logic [dims-1:0]             next_last;
    logic [tag_w-1:0]            run_tag;
    logic [tag_w-1:0]            next_tag;
    logic [dims-1:0]             step_en;
    logic                        beat_fire;

    assign beat_fire = beat.valid && beat.ready;

    // a dimension steps when all inner ones sit at their last index
    always_comb begin
        step_en[0] = 1'b1;
        for (int i = 1; i < dims; i++) begin
            step_en[i] = run_last[i-1];
        end
    end

    always_comb begin
        next_state = state;
        next_addr  = run_addr;
        next_len   = run_len;
        next_first = run_first;
        next_tag   = run_tag;

        if (state == stride_pkg::idle) begin
            if (cmd.valid) begin
                next_state = stride_pkg::walking;
                for (int i = 0; i < dims; i++) begin
                    next_addr[i]  = cmd.base;
                    next_len[i]   = cmd.len[i];
                    next_first[i] = 1'b1;
                end
                next_tag = cmd.tag;
            end
        end else if (beat_fire) begin
            if (run_last[dims-1]) begin
                next_state = stride_pkg::idle;
            end else begin
                for (int i = 0; i < dims; i++) begin
                    next_first[i] = 1'b0;
                    if (step_en[i]) begin
                        next_addr[i] = run_addr[i] + addr_w'(cmd.step[i]);
                        if (run_last[i]) begin
                            next_len[i]   = cmd.len[i];
                            next_first[i] = 1'b1;
                        end else begin
                            next_len[i] = run_len[i] - len_w'(1);
                        end
                    end
                end
                // wrapped dimensions restart at the outer one's new address
                for (int i = dims - 2; i >= 0; i--) begin
                    if (run_last[i]) begin
                        next_addr[i] = next_addr[i+1];
                    end
                end
            end
        end

        // cascaded last flags
        next_last[0] = (next_len[0] == '0);
        for (int i = 1; i < dims; i++) begin
            next_last[i] = next_last[i-1] && (next_len[i] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stride_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        run_addr  <= next_addr;
        run_len   <= next_len;
        run_first <= next_first;
        run_last  <= next_last;
        run_tag   <= next_tag;
    end

    // --------------------
    // stream outputs
    // --------------------
    assign beat.addr  = run_addr[0];
    assign beat.first = run_first;
    assign beat.last  = run_last;
    assign beat.tag   = run_tag;
    assign beat.valid = (state == stride_pkg::walking);

    // command retires with the final beat
    assign cmd.ready = beat_fire && run_last[dims-1];

endmodule

`default_nettype wire

//--- src/cmd_skid_buffer.sv
/*
 * two-entry command buffer with main and skid registers,
 * ready is registered so the input path is cut
 */

`timescale 1ns/1ps
`default_nettype none

module cmd_skid_buffer #(
    parameter int dims   = stride_pkg::dims_default,
    parameter int addr_w = stride_pkg::addr_w_default,
    parameter int step_w = stride_pkg::step_w_default,
    parameter int len_w  = stride_pkg::len_w_default,
    parameter int tag_w  = stride_pkg::tag_w_default
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [addr_w-1:0]           cmd_base,
    input  logic [dims-1:0][step_w-1:0] cmd_step,
    input  logic [dims-1:0][len_w-1:0]  cmd_len,
    input  logic [tag_w-1:0]            cmd_tag,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    cmd_if.source                       queued
);

    localparam int cmd_w = addr_w + dims * (step_w + len_w) + tag_w;

    logic [cmd_w-1:0] in_cmd;
    logic [cmd_w-1:0] main_cmd;
    logic [cmd_w-1:0] skid_cmd;
    logic             main_valid;
    logic             skid_valid;
    logic             in_fire;
    logic             main_free;

    assign in_cmd    = {cmd_base, cmd_step, cmd_len, cmd_tag};
    // room for one more as long as the skid slot is empty
    assign cmd_ready = !skid_valid;
    assign in_fire   = cmd_valid && cmd_ready;
    assign main_free = !main_valid || queued.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            main_valid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    // skid entry is older, it goes first
    always_ff @(posedge clk) begin
        if (main_free) begin
            main_cmd <= skid_valid ? skid_cmd : in_cmd;
        end else if (in_fire) begin
            skid_cmd <= in_cmd;
        end
    end

    assign queued.valid = main_valid;
    assign {queued.base, queued.step, queued.len, queued.tag} = main_cmd;

endmodule

`default_nettype wire

//--- src/stream_if.sv
/*
 * command and address-beat stream interfaces, valid/ready handshake
 */

`timescale 1ns/1ps
`default_nettype none

// command stream, one transfer per strided walk
interface cmd_if #(
    parameter int dims   = stride_pkg::dims_default,
    parameter int addr_w = stride_pkg::addr_w_default,
    parameter int step_w = stride_pkg::step_w_default,
    parameter int len_w  = stride_pkg::len_w_default,
    parameter int tag_w  = stride_pkg::tag_w_default
);
    logic [addr_w-1:0]            base;
    logic [dims-1:0][step_w-1:0]  step;
    logic [dims-1:0][len_w-1:0]   len;
    logic [tag_w-1:0]             tag;
    logic                         valid;
    logic                         ready;

    modport source (output base, step, len, tag, valid, input ready);
    modport sink   (input base, step, len, tag, valid, output ready);
endinterface

// one address per beat, flags per dimension
interface beat_if #(
    parameter int dims   = stride_pkg::dims_default,
    parameter int addr_w = stride_pkg::addr_w_default,
    parameter int tag_w  = stride_pkg::tag_w_default
);
    logic [addr_w-1:0] addr;
    logic [dims-1:0]   first;
    logic [dims-1:0]   last;
    logic [tag_w-1:0]  tag;
    logic              valid;
    logic              ready;

    modport source (output addr, first, last, tag, valid, input ready);
    modport sink   (input addr, first, last, tag, valid, output ready);
endinterface

`default_nettype wire

//--- src/stride_pkg.sv
/*
 * default widths, dimension count and generator state type
 * for the strided read engine
 */

`default_nettype none

package stride_pkg;

    // --------------------
    // geometry defaults
    // --------------------

    // generator supports 1 to 4 dimensions
    parameter int dims_default = 3;

    // word address into the local buffer
    parameter int addr_w_default = 10;

    // steps wrap modulo the address width
    parameter int step_w_default = 10;

    // per-dimension length, stored as count minus one
    parameter int len_w_default = 4;

    // --------------------
    // payload defaults
    // --------------------
    parameter int data_w_default = 16;
    parameter int tag_w_default  = 4;

    // address generator state
    typedef enum logic [0:0] {
        idle    = 1'b0,
        walking = 1'b1
    } gen_state_e;

endpackage

`default_nettype wire
